// ==== filelist.f ====
+incdir+bench
rtl/sd_cmd_pkg.sv
rtl/sd_timing_pkg.sv
rtl/sd_line_sync.sv
rtl/cmd_receiver.sv
rtl/cmd_responder.sv
rtl/sd_cmd_top.sv
bench/sd_cmd_properties.sv
bench/tb_sd_cmd.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_sd_cmd
RTL_TOP  := sd_cmd_top
FILELIST := filelist.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/sd_host_tasks.svh ====
`ifndef SD_HOST_TASKS_SVH
`define SD_HOST_TASKS_SVH

// host side of the CMD line, included inside tb_sd_cmd
// the host drives on the SD falling edge and samples on the rising edge

// let the SD clock run with the host line idle
task automatic idle_sd_clocks(input int unsigned count);
   repeat (count) @(posedge sd_clk_i);
   #1;
endtask

// drive one frame msb first, then release the line
// end_stamp is the SD rising edge count at which the card samples the end bit
task automatic send_command(input logic [CMD_FRAME_BITS-1:0] frame,
                            output int unsigned end_stamp);
   for (int i = CMD_FRAME_BITS - 1; i >= 0; i--) begin
      @(negedge sd_clk_i);
      #1;
      sd_cmd_i = frame[i];
   end
   @(posedge sd_clk_i);
   #1;
   end_stamp = sd_rise_count;
   @(negedge sd_clk_i);
   #1;
   sd_cmd_i = 1'b1;
endtask

// wait for a start bit on the card line, then take the remaining bits
task automatic capture_response(output logic [CMD_FRAME_BITS-1:0] bits,
                                output int unsigned start_stamp);
   int unsigned waited;
   waited      = 0;
   start_stamp = 0;
   bits        = '1;
   while (start_stamp == 0) begin
      @(posedge sd_clk_i);
      #1;
      if (card_line === 1'b0) begin
         start_stamp = sd_rise_count;
      end else if (waited == START_WAIT_LIMIT) begin
         stop_run("no response start bit appeared on the CMD line");
      end
      waited++;
   end
   bits[CMD_FRAME_BITS-1] = 1'b0;
   for (int i = CMD_FRAME_BITS - 2; i >= 0; i--) begin
      @(posedge sd_clk_i);
      #1;
      bits[i] = card_line;
   end
endtask

`endif

// ==== bench/tb_sd_cmd.sv ====
`timescale 1ns/1ps

module tb_sd_cmd;
   import sd_cmd_pkg::*;
   import sd_timing_pkg::*;

   localparam int unsigned RESP_DELAY_MIN   = 4;
   localparam int unsigned RESP_DELAY_MAX   = 24;
   localparam int unsigned NUM_FRAMES       = 40;
   localparam int unsigned CLK_PERIOD       = 8;
   localparam int unsigned SD_PERIOD        = 80;
   // 200 SD periods per frame is well above the longest frame
   localparam int unsigned CYCLE_LIMIT      = NUM_FRAMES * 200 * SD_PERIOD / CLK_PERIOD;
   localparam int unsigned START_WAIT_LIMIT = Z_CLOCKS + RESP_DELAY_MAX + 8;
   localparam int unsigned CLK_WAIT_LIMIT   = 64 * SD_PERIOD / CLK_PERIOD;

   // frame kinds
   localparam int unsigned KIND_RESP        = 0;
   localparam int unsigned KIND_RESP_NO_CRC = 1;
   localparam int unsigned KIND_TIMEOUT     = 2;
   localparam int unsigned KIND_BAD_CRC     = 3;
   localparam int unsigned KIND_BAD_END     = 4;
   localparam int unsigned KIND_FILTERED    = 5;
   localparam int unsigned NUM_KINDS        = 6;

   logic        clk;
   logic        resetn;
   logic        sd_clk_i;
   logic        sd_cmd_i;
   logic        sd_cmd_o;
   logic        sd_cmd_t_o;
   logic        cmd_valid_o;
   cmd_frame_t  cmd_o;
   resp_frame_t resp_i;
   logic        resp_req_i;
   logic        resp_ack_o;
   logic        resp_timeout_o;

   logic        card_line;
   logic        line_must_idle;
   logic [31:0] rng_state;
   cmd_frame_t  last_cmd;
   int unsigned sd_rise_count = 0;
   int unsigned valid_count   = 0;
   int unsigned timeout_count = 0;
   int unsigned cycle_count   = 0;

   sd_cmd_top #(
      .resp_delay_min(RESP_DELAY_MIN),
      .resp_delay_max(RESP_DELAY_MAX)
   ) uut (
      .clk           (clk),
      .resetn        (resetn),
      .sd_clk_i      (sd_clk_i),
      .sd_cmd_i      (sd_cmd_i),
      .sd_cmd_o      (sd_cmd_o),
      .sd_cmd_t_o    (sd_cmd_t_o),
      .cmd_valid_o   (cmd_valid_o),
      .cmd_o         (cmd_o),
      .resp_i        (resp_i),
      .resp_req_i    (resp_req_i),
      .resp_ack_o    (resp_ack_o),
      .resp_timeout_o(resp_timeout_o)
   );

   // open-drain CMD line as the host sees it
   assign card_line = sd_cmd_t_o ? 1'b1 : sd_cmd_o;

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      sd_clk_i = 1'b0;
      forever #(SD_PERIOD / 2) sd_clk_i = ~sd_clk_i;
   end

   always @(posedge sd_clk_i) begin
      sd_rise_count <= sd_rise_count + 1;
   end

   // event counters, global watchdog and the released-line watch
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cmd_valid_o) begin
         valid_count <= valid_count + 1;
         last_cmd    <= cmd_o;
      end
      if (resp_timeout_o) begin
         timeout_count <= timeout_count + 1;
      end
      if (line_must_idle && !sd_cmd_t_o) begin
         stop_run("the card drove the CMD line when no response was due");
      end
      if (cycle_count == CYCLE_LIMIT) begin
         stop_run($sformatf("the run did not finish within %0d clk cycles", CYCLE_LIMIT));
      end
   end

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_error(input string msg);
      stop_run($sformatf("error at %0d ns: %s", $time, msg));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // divide the 40 covered bits times x^7 by x^7 + x^3 + 1
   function automatic crc7_t model_crc7(input logic [39:0] bits);
      logic [46:0] dividend;
      crc7_t       rem;
      logic        top;
      dividend = {bits, 7'b0};
      rem      = '0;
      for (int i = 46; i >= 0; i--) begin
         top = rem[6];
         rem = {rem[5:0], dividend[i]};
         if (top) begin
            rem = rem ^ 7'h09;
         end
      end
      return rem;
   endfunction

   task automatic check_cmd(input cmd_frame_t got, input cmd_frame_t exp);
      if (got !== exp) begin
         report_error($sformatf("cmd_o {crc_err,index,arg} is %h, expected %h", got, exp));
      end
   endtask

   task automatic check_resp(input logic [CMD_FRAME_BITS-1:0] bits,
                             input resp_frame_t exp, input crc7_t exp_crc);
      resp_frame_t got;
      // no_crc never travels on the line so the crc field stands for it
      got.no_crc  = exp.no_crc;
      got.index   = bits[45:40];
      got.content = bits[39:8];
      if (bits[47:46] !== 2'b00 || bits[0] !== 1'b1) begin
         report_error($sformatf("response framing bits wrong in %h", bits));
      end
      if (got !== exp) begin
         report_error($sformatf("response is %h, expected %h", got, exp));
      end
      if (bits[7:1] !== exp_crc) begin
         report_error($sformatf("response crc field %h, expected %h", bits[7:1], exp_crc));
      end
   endtask

   task automatic check_count(input int unsigned got, input int unsigned exp, input string what);
      if (got != exp) begin
         report_error($sformatf("%s counted %0d, expected %0d", what, got, exp));
      end
   endtask

   task automatic wait_cmd_valid(input int unsigned exp_count);
      int unsigned waited;
      waited = 0;
      while (valid_count != exp_count) begin
         if (waited == CLK_WAIT_LIMIT) begin
            stop_run("cmd_valid_o did not pulse after a host command");
         end
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   task automatic wait_timeout_pulse(input int unsigned exp_count);
      int unsigned waited;
      waited = 0;
      while (timeout_count != exp_count) begin
         if (waited == CLK_WAIT_LIMIT) begin
            stop_run("resp_timeout_o did not pulse without a request");
         end
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   task automatic wait_ack(input logic level);
      int unsigned waited;
      waited = 0;
      while (resp_ack_o !== level) begin
         if (waited == CLK_WAIT_LIMIT) begin
            stop_run($sformatf("resp_ack_o never went to %b", level));
         end
         @(posedge clk);
         #1;
         waited++;
      end
   endtask

   `include "sd_host_tasks.svh"

   initial begin
      logic [CMD_FRAME_BITS-1:0] frame;
      logic [CMD_FRAME_BITS-1:0] resp_bits;
      logic [31:0]               r;
      int unsigned               kind;
      int unsigned               end_stamp;
      int unsigned               start_stamp;
      int unsigned               exp_valids;
      int unsigned               exp_timeouts;
      cmd_frame_t                exp_cmd;
      resp_frame_t               exp_resp;
      crc7_t                     crc;
      logic                      tx_bit;
      logic                      end_bit;

      rng_state      = 32'd81;
      resetn         = 1'b0;
      sd_cmd_i       = 1'b1;
      resp_i         = '0;
      resp_req_i     = 1'b0;
      line_must_idle = 1'b0;
      exp_valids     = 0;
      exp_timeouts   = 0;
      repeat (3) @(posedge clk);
      #1;
      resetn = 1'b1;
      idle_sd_clocks(4);

      for (int n = 0; n < NUM_FRAMES; n++) begin
         // the first frames walk every kind once
         kind = (n < NUM_KINDS) ? n : next_random() % NUM_KINDS;
         r               = next_random();
         exp_cmd.index   = r[5:0];
         exp_cmd.arg     = next_random();
         exp_cmd.crc_err = (kind == KIND_BAD_CRC || kind == KIND_BAD_END);
         tx_bit          = (kind != KIND_FILTERED);
         end_bit         = (kind != KIND_BAD_END);
         crc             = model_crc7({1'b0, tx_bit, exp_cmd.index, exp_cmd.arg});
         if (kind == KIND_BAD_CRC) begin
            crc = crc ^ (7'h01 << (r[10:8] % 7));
         end
         frame          = {1'b0, tx_bit, exp_cmd.index, exp_cmd.arg, crc, end_bit};
         line_must_idle = !(kind == KIND_RESP || kind == KIND_RESP_NO_CRC);

         send_command(frame, end_stamp);
         if (kind == KIND_FILTERED) begin
            idle_sd_clocks(4);
            check_count(valid_count, exp_valids, "cmd_valid_o pulses");
         end else begin
            exp_valids++;
            wait_cmd_valid(exp_valids);
            check_cmd(last_cmd, exp_cmd);
         end

         if (kind == KIND_RESP || kind == KIND_RESP_NO_CRC) begin
            r                = next_random();
            exp_resp.no_crc  = (kind == KIND_RESP_NO_CRC);
            exp_resp.index   = r[5:0];
            exp_resp.content = next_random();
            @(posedge clk);
            #1;
            resp_i     = exp_resp;
            resp_req_i = 1'b1;
            capture_response(resp_bits, start_stamp);
            if (start_stamp - end_stamp < Z_CLOCKS + RESP_DELAY_MIN) begin
               report_error($sformatf("response began %0d SD clocks after the command",
                                      start_stamp - end_stamp));
            end
            crc = exp_resp.no_crc ? 7'h7f :
                  model_crc7({2'b00, exp_resp.index, exp_resp.content});
            check_resp(resp_bits, exp_resp, crc);
            wait_ack(1'b1);
            @(posedge clk);
            #1;
            resp_req_i = 1'b0;
            wait_ack(1'b0);
         end else if (kind == KIND_TIMEOUT) begin
            exp_timeouts++;
            wait_timeout_pulse(exp_timeouts);
         end

         // gap so the responder is back in idle before the next command
         idle_sd_clocks(4);
         check_count(valid_count, exp_valids, "cmd_valid_o pulses");
         check_count(timeout_count, exp_timeouts, "resp_timeout_o pulses");
      end

      if (uut.u_responder.u_props.assert_failures == 0) begin
         $display("TEST PASS");
      end else begin
         $display("a bound assertion on the responder failed");
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== bench/sd_cmd_properties.sv ====
`timescale 1ns/1ps

module sd_cmd_properties (
   input logic clk,
   input logic resetn,
   input logic resp_req_i,
   input logic resp_ack_i,
   input logic resp_busy_i,
   input logic cmd_drive_i
);

   // read by the testbench at the end of the run
   int unsigned assert_failures = 0;

   // the ack only ever answers a pending request
   ack_needs_req: assert property (
      @(posedge clk) disable iff (!resetn)
      $rose(resp_ack_i) |-> resp_req_i
   ) else begin
      assert_failures <= assert_failures + 1;
      $error("resp_ack_o rose while resp_req_i was low");
   end

   // the card drives CMD only while a response is in flight
   drive_in_response: assert property (
      @(posedge clk) disable iff (!resetn)
      cmd_drive_i |-> resp_busy_i
   ) else begin
      assert_failures <= assert_failures + 1;
      $error("cmd_drive_o high while the responder is idle");
   end

endmodule

bind cmd_responder sd_cmd_properties u_props (
   .clk        (clk),
   .resetn     (resetn),
   .resp_req_i (resp_req_i),
   .resp_ack_i (resp_ack_o),
   .resp_busy_i(resp_busy_o),
   .cmd_drive_i(cmd_drive_o)
);

// ==== rtl/sd_cmd_top.sv ====
`timescale 1ns/1ps

module sd_cmd_top #(
   parameter int unsigned resp_delay_min = sd_timing_pkg::DEFAULT_RESP_DELAY_MIN,
   parameter int unsigned resp_delay_max = sd_timing_pkg::DEFAULT_RESP_DELAY_MAX
) (
   input  logic                    clk,
   input  logic                    resetn,
   // SD bus, card side
   input  logic                    sd_clk_i,
   input  logic                    sd_cmd_i,
   output logic                    sd_cmd_o,
   output logic                    sd_cmd_t_o,
   // received commands
   output logic                    cmd_valid_o,
   output sd_cmd_pkg::cmd_frame_t  cmd_o,
   // response request, four-phase with resp_ack_o
   input  sd_cmd_pkg::resp_frame_t resp_i,
   input  logic                    resp_req_i,
   output logic                    resp_ack_o,
   output logic                    resp_timeout_o
);

   logic sd_tick;
   logic cmd_in;
   logic cmd_out;
   logic cmd_drive;
   logic resp_busy;

   sd_line_sync u_line_sync (
      .clk        (clk),
      .resetn     (resetn),
      .sd_clk_i   (sd_clk_i),
      .sd_cmd_i   (sd_cmd_i),
      .cmd_out_i  (cmd_out),
      .cmd_drive_i(cmd_drive),
      .sd_tick_o  (sd_tick),
      .cmd_in_o   (cmd_in),
      .sd_cmd_o   (sd_cmd_o),
      .sd_cmd_t_o (sd_cmd_t_o)
   );

   cmd_receiver u_receiver (
      .clk        (clk),
      .resetn     (resetn),
      .sd_tick_i  (sd_tick),
      .cmd_in_i   (cmd_in),
      .resp_busy_i(resp_busy),
      .cmd_valid_o(cmd_valid_o),
      .cmd_frame_o(cmd_o)
   );

   cmd_responder #(
      .resp_delay_min(resp_delay_min),
      .resp_delay_max(resp_delay_max)
   ) u_responder (
      .clk           (clk),
      .resetn        (resetn),
      .sd_tick_i     (sd_tick),
      .cmd_valid_i   (cmd_valid_o),
      .cmd_frame_i   (cmd_o),
      .resp_i        (resp_i),
      .resp_req_i    (resp_req_i),
      .resp_ack_o    (resp_ack_o),
      .resp_timeout_o(resp_timeout_o),
      .resp_busy_o   (resp_busy),
      .cmd_out_o     (cmd_out),
      .cmd_drive_o   (cmd_drive)
   );

endmodule

// ==== rtl/cmd_responder.sv ====
`timescale 1ns/1ps

module cmd_responder #(
   parameter int unsigned resp_delay_min = sd_timing_pkg::DEFAULT_RESP_DELAY_MIN,
   parameter int unsigned resp_delay_max = sd_timing_pkg::DEFAULT_RESP_DELAY_MAX
) (
   input  logic                    clk,
   input  logic                    resetn,
   input  logic                    sd_tick_i,
   input  logic                    cmd_valid_i,
   input  sd_cmd_pkg::cmd_frame_t  cmd_frame_i,
   input  sd_cmd_pkg::resp_frame_t resp_i,
   input  logic                    resp_req_i,
   output logic                    resp_ack_o,
   output logic                    resp_timeout_o,
   output logic                    resp_busy_o,
   output logic                    cmd_out_o,
   output logic                    cmd_drive_o
);
   import sd_cmd_pkg::*;
   import sd_timing_pkg::*;

   typedef enum logic [2:0] {
      state_idle,
      state_z_clocks,
      state_delay,
      state_writing,
      state_writing_crc,
      state_ack_high,
      state_ack_release
   } state_t;

   state_t                   state_q;
   sd_count_t                cnt_q;
   sd_count_t                cnt_next;
   crc7_t                    crc_q;
   crc7_t                    crc_field;
   logic [CRC_SPAN_BITS-1:0] shift_q;
   logic [CRC_SPAN_BITS-1:0] resp_load;
   logic                     start_now;
   logic                     timeout_now;
   logic                     body_done;

   assign cnt_next  = cnt_q + 1'b1;

   // start bit 0, transmission bit 0, then index and content
   assign resp_load = {1'b0, 1'b0, resp_i.index, resp_i.content};
   assign crc_field = resp_i.no_crc ? '1 : crc_q;

   // cnt_next is the number of delay ticks including this one
   assign start_now   = sd_tick_i && state_q == state_delay && resp_req_i &&
                        cnt_next >= sd_count_t'(resp_delay_min);
   assign timeout_now = sd_tick_i && state_q == state_delay && !start_now &&
                        cnt_next >= sd_count_t'(resp_delay_max);

   // all 40 covered bits are out, this tick launches the first crc bit
   assign body_done   = sd_tick_i && state_q == state_writing &&
                        cnt_q == sd_count_t'(CRC_SPAN_BITS);

   assign resp_busy_o = state_q != state_idle;

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state_q        <= state_idle;
         cnt_q          <= '0;
         resp_ack_o     <= 1'b0;
         resp_timeout_o <= 1'b0;
         cmd_out_o      <= 1'b1;
         cmd_drive_o    <= 1'b0;
      end else begin
         resp_timeout_o <= timeout_now;

         // drive ends one tick after the end bit is launched
         if (sd_tick_i) begin
            cmd_drive_o <= start_now || state_q == state_writing ||
                           state_q == state_writing_crc;
         end

         case (state_q)
            state_idle: begin
               // bad commands never get a response
               if (cmd_valid_i && !cmd_frame_i.crc_err) begin
                  state_q <= state_z_clocks;
                  cnt_q   <= '0;
               end
            end
            state_z_clocks: begin
               if (sd_tick_i) begin
                  if (cnt_next == sd_count_t'(Z_CLOCKS)) begin
                     state_q <= state_delay;
                     cnt_q   <= '0;
                  end else begin
                     cnt_q <= cnt_next;
                  end
               end
            end
            state_delay: begin
               if (start_now) begin
                  state_q   <= state_writing;
                  cnt_q     <= sd_count_t'(1);
                  cmd_out_o <= resp_load[CRC_SPAN_BITS-1];
               end else if (timeout_now) begin
                  state_q <= state_idle;
               end else if (sd_tick_i) begin
                  cnt_q <= cnt_next;
               end
            end
            state_writing: begin
               if (body_done) begin
                  state_q   <= state_writing_crc;
                  cnt_q     <= sd_count_t'(1);
                  cmd_out_o <= crc_field[6];
               end else if (sd_tick_i) begin
                  cnt_q     <= cnt_next;
                  cmd_out_o <= shift_q[CRC_SPAN_BITS-1];
               end
            end
            state_writing_crc: begin
               if (sd_tick_i) begin
                  cmd_out_o <= shift_q[CRC_SPAN_BITS-1];
                  cnt_q     <= cnt_next;
                  // six more crc bits, then the end bit on this tick
                  if (cnt_q == sd_count_t'($bits(crc7_t))) begin
                     state_q    <= state_ack_high;
                     resp_ack_o <= 1'b1;
                  end
               end
            end
            state_ack_high: begin
               if (!resp_req_i) begin
                  state_q    <= state_ack_release;
                  resp_ack_o <= 1'b0;
               end
            end
            state_ack_release: begin
               // one more SD clock so the line is released before the
               // receiver listens again
               if (sd_tick_i) begin
                  state_q <= state_idle;
               end
            end
            default: begin
               state_q <= state_idle;
            end
         endcase
      end
   end

   // response shift register and running crc
   always_ff @(posedge clk) begin
      if (start_now) begin
         shift_q <= {resp_load[CRC_SPAN_BITS-2:0], 1'b0};
         crc_q   <= crc7_step(crc7_t'(0), resp_load[CRC_SPAN_BITS-1]);
      end else if (body_done) begin
         // remaining crc bits, end bit 1, zero padding
         shift_q <= {crc_field[5:0], 1'b1, {(CRC_SPAN_BITS - 7){1'b0}}};
      end else if (sd_tick_i && state_q == state_writing) begin
         shift_q <= {shift_q[CRC_SPAN_BITS-2:0], 1'b0};
         crc_q   <= crc7_step(crc_q, shift_q[CRC_SPAN_BITS-1]);
      end else if (sd_tick_i && state_q == state_writing_crc) begin
         shift_q <= {shift_q[CRC_SPAN_BITS-2:0], 1'b0};
      end
   end

endmodule

// ==== rtl/cmd_receiver.sv ====
`timescale 1ns/1ps

module cmd_receiver (
   input  logic                   clk,
   input  logic                   resetn,
   input  logic                   sd_tick_i,
   input  logic                   cmd_in_i,
   input  logic                   resp_busy_i,
   output logic                   cmd_valid_o,
   output sd_cmd_pkg::cmd_frame_t cmd_frame_o
);
   import sd_cmd_pkg::*;
   import sd_timing_pkg::*;

   localparam int unsigned TX_BIT = CMD_FRAME_BITS - 2;

   typedef enum logic {
      state_idle,
      state_reading
   } state_t;

   state_t                    state_q;
   sd_count_t                 bit_cnt_q;
   crc7_t                     crc_q;
   logic [CMD_FRAME_BITS-1:0] shift_q;
   logic [CMD_FRAME_BITS-1:0] frame_next;
   logic                      start_bit;
   logic                      frame_done;
   logic                      frame_bad;

   // frame layout, msb first on the line
   // [47] start, [46] transmission, [45:40] index, [39:8] argument,
   // [7:1] crc7, [0] end
   assign frame_next = {shift_q[CMD_FRAME_BITS-2:0], cmd_in_i};

   // our own response is on the line while busy
   assign start_bit  = sd_tick_i && !cmd_in_i && !resp_busy_i;

   // this tick samples the 48th bit
   assign frame_done = sd_tick_i && state_q == state_reading &&
                       bit_cnt_q == sd_count_t'(CMD_FRAME_BITS - 1);

   // a bad end bit counts as a CRC error
   assign frame_bad  = frame_next[7:1] != crc_q || !frame_next[0];

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         state_q     <= state_idle;
         bit_cnt_q   <= '0;
         cmd_valid_o <= 1'b0;
      end else begin
         // frames sent by a card have transmission bit 0
         cmd_valid_o <= frame_done && frame_next[TX_BIT];
         case (state_q)
            state_idle: begin
               if (start_bit) begin
                  state_q   <= state_reading;
                  bit_cnt_q <= sd_count_t'(1);
               end
            end
            state_reading: begin
               if (frame_done) begin
                  state_q <= state_idle;
               end
               if (sd_tick_i) begin
                  bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            default: begin
               state_q <= state_idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (sd_tick_i) begin
         shift_q <= frame_next;
      end

      // crc runs over the first 40 bits, start bit included
      if (state_q == state_idle && start_bit) begin
         crc_q <= crc7_step(crc7_t'(0), cmd_in_i);
      end else if (sd_tick_i && state_q == state_reading &&
                   bit_cnt_q < CRC_SPAN_BITS) begin
         crc_q <= crc7_step(crc_q, cmd_in_i);
      end

      if (frame_done && frame_next[TX_BIT]) begin
         cmd_frame_o.crc_err <= frame_bad;
         cmd_frame_o.index   <= frame_next[45:40];
         cmd_frame_o.arg     <= frame_next[39:8];
      end
   end

endmodule

// ==== rtl/sd_line_sync.sv ====
`timescale 1ns/1ps

module sd_line_sync (
   input  logic clk,
   input  logic resetn,
   input  logic sd_clk_i,
   input  logic sd_cmd_i,
   input  logic cmd_out_i,
   input  logic cmd_drive_i,
   output logic sd_tick_o,
   output logic cmd_in_o,
   output logic sd_cmd_o,
   output logic sd_cmd_t_o
);
   import sd_timing_pkg::*;

   logic                   sd_toggle;
   logic                   cmd_capture;
   logic [SYNC_STAGES-1:0] toggle_sync;
   logic [SYNC_STAGES-1:0] cmd_sync;

   // one toggle per SD clock period, flips on the falling edge
   always_ff @(negedge sd_clk_i or negedge resetn) begin
      if (!resetn) begin
         sd_toggle <= 1'b0;
      end else begin
         sd_toggle <= ~sd_toggle;
      end
   end

   // host drives CMD on the falling edge, so sample on the rising edge
   // idle level is 1 so no start bit is seen out of reset
   always_ff @(posedge sd_clk_i or negedge resetn) begin
      if (!resetn) begin
         cmd_capture <= 1'b1;
      end else begin
         cmd_capture <= sd_cmd_i;
      end
   end

   always_ff @(posedge clk or negedge resetn) begin
      if (!resetn) begin
         toggle_sync <= '0;
         cmd_sync    <= '1;
      end else begin
         toggle_sync <= {toggle_sync[SYNC_STAGES-2:0], sd_toggle};
         cmd_sync    <= {cmd_sync[SYNC_STAGES-2:0], cmd_capture};
      end
   end

   // the tick lands after the falling edge, when the bit captured on the
   // preceding rising edge has long settled in cmd_sync
   assign sd_tick_o = toggle_sync[SYNC_STAGES-1] ^ toggle_sync[SYNC_STAGES-2];
   assign cmd_in_o  = cmd_sync[SYNC_STAGES-1];

   // card output changes on the falling edge, held through the host sample
   always_ff @(negedge sd_clk_i or negedge resetn) begin
      if (!resetn) begin
         sd_cmd_o   <= 1'b1;
         sd_cmd_t_o <= 1'b1;
      end else begin
         sd_cmd_o   <= cmd_drive_i ? cmd_out_i : 1'b1;
         sd_cmd_t_o <= ~cmd_drive_i;
      end
   end

endmodule

// ==== rtl/sd_timing_pkg.sv ====
package sd_timing_pkg;

   // counts SD clock ticks inside one state
   typedef logic [7:0] sd_count_t;

   // bits in a command or a 48-bit response
   localparam int unsigned CMD_FRAME_BITS = 48;

   // leading bits covered by the CRC7: start, transmission, index, argument
   localparam int unsigned CRC_SPAN_BITS = CMD_FRAME_BITS - 8;

   // released clocks between the command end bit and the delay window
   localparam int unsigned Z_CLOCKS = 2;

   // flops between the SD clock domain and clk
   localparam int unsigned SYNC_STAGES = 3;

   // NCR window, counted after the Z clocks
   // 5 clocks NID for CMD2 and ACMD41, minus the Z clocks
   localparam int unsigned DEFAULT_RESP_DELAY_MIN = 3;
   localparam int unsigned DEFAULT_RESP_DELAY_MAX = 32;

endpackage

// ==== rtl/sd_cmd_pkg.sv ====
package sd_cmd_pkg;

   // command fields as they appear on the CMD line
   typedef logic [5:0]  cmd_index_t;
   typedef logic [31:0] cmd_arg_t;
   typedef logic [6:0]  crc7_t;

   // a command as published to the user side
   typedef struct packed {
      // bad CRC7 or end bit 0
      logic       crc_err;
      cmd_index_t index;
      cmd_arg_t   arg;
   } cmd_frame_t;

   // a 48-bit response as requested by the user side
   typedef struct packed {
      // send seven ones in place of the CRC7
      logic       no_crc;
      cmd_index_t index;
      cmd_arg_t   content;
   } resp_frame_t;

   // x^7 + x^3 + 1
   localparam crc7_t CRC7_POLY = 7'h09;

   // advance the serial CRC7 by one line bit, msb first
   function automatic crc7_t crc7_step(input crc7_t crc, input logic line_bit);
      logic feedback;
      feedback = line_bit ^ crc[6];
      return {crc[5:0], 1'b0} ^ (CRC7_POLY & {7{feedback}});
   endfunction

endpackage
